/* logic/eeprom_ctrl_top.sv */
module eeprom_ctrl_top #(
    parameter int SCL_HALF = 4  // clocks per half scl period
) (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    req_valid,
    input  eeprom_pkg::eeprom_req_t req,
    output logic                    busy,
    output logic                    rsp_valid,
    output eeprom_pkg::eeprom_rsp_t rsp,
    output logic                    scl,
    output logic                    sda_out,
    output logic                    sda_oe,
    input  logic                    sda_in
);

    logic                    txn_start;
    logic                    txn_write;
    logic                    op_valid;
    eeprom_pkg::twi_op_t     op;
    logic                    op_done;
    eeprom_pkg::twi_status_t status;

    eeprom_txn_decode u_decode (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .txn_start (txn_start),
        .txn_write (txn_write),
        .op_valid  (op_valid),
        .op        (op),
        .op_done   (op_done)
    );

    twi_bit_engine #(
        .SCL_HALF (SCL_HALF)
    ) u_engine (
        .CLK      (CLK),
        .RESET    (RESET),
        .op_valid (op_valid),
        .op       (op),
        .op_done  (op_done),
        .status   (status),
        .scl      (scl),
        .sda_out  (sda_out),
        .sda_oe   (sda_oe),
        .sda_in   (sda_in)
    );

    // sees the same op_done/status as decode
    eeprom_rsp_collect u_collect (
        .CLK       (CLK),
        .RESET     (RESET),
        .txn_start (txn_start),
        .txn_write (txn_write),
        .op_done   (op_done),
        .status    (status),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

/* logic/eeprom_pkg.sv */
package eeprom_pkg;

    // 24xx16 style part, 2 kbyte
    localparam logic [3:0] EEPROM_DEV_CODE = 4'b1010;
    localparam int         EEPROM_ADDR_W   = 11;

    // bus level operations handed to the bit engine
    typedef enum logic [1:0] {
        OP_START      = 2'd0, // also used for the repeated start
        OP_STOP       = 2'd1,
        OP_WRITE_BYTE = 2'd2,
        OP_READ_BYTE  = 2'd3
    } twi_op_e;

    typedef enum logic [3:0] {
        S_IDLE      = 4'd0,
        S_START     = 4'd1,
        S_CTRL_W    = 4'd2,
        S_ADDR      = 4'd3,
        S_DATA      = 4'd4,
        S_RESTART   = 4'd5,
        S_CTRL_R    = 4'd6,
        S_READ      = 4'd7,
        S_STOP      = 4'd8,
        S_WAIT_DONE = 4'd9  // response goes out here
    } seq_state_e;

    // host request, write or random read
    typedef struct packed {
        logic                     write;
        logic [EEPROM_ADDR_W-1:0] addr;
        logic [7:0]               wdata;
    } eeprom_req_t;

    typedef struct packed {
        logic       write;
        logic [7:0] rdata; // zero on writes
        logic       nack;  // some byte was not acknowledged
    } eeprom_rsp_t;

    typedef struct packed {
        twi_op_e    op;
        logic [7:0] wbyte;
    } twi_op_t;

    typedef struct packed {
        twi_op_e    op;
        logic [7:0] rbyte;
        logic       ack_missing;
    } twi_status_t;

endpackage

/* logic/eeprom_rsp_collect.sv */
module eeprom_rsp_collect (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    txn_start,
    input  logic                    txn_write,
    input  logic                    op_done,
    input  eeprom_pkg::twi_status_t status,
    output logic                    rsp_valid,
    output eeprom_pkg::eeprom_rsp_t rsp
);

    logic       write_q;
    logic [7:0] rdata_q;
    logic       nack_q;   // sticky over the whole transaction

    assign rsp.write = write_q;
    assign rsp.rdata = rdata_q;
    assign rsp.nack  = nack_q;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            rsp_valid <= 1'b0;
            write_q   <= 1'b0;
            rdata_q   <= 8'h00;
            nack_q    <= 1'b0;
        end
        else
        begin
            rsp_valid <= 1'b0;
            if (txn_start)
            begin
                write_q <= txn_write;
                rdata_q <= 8'h00;
                nack_q  <= 1'b0;
            end
            else if (op_done)
            begin
                case (status.op)
                    eeprom_pkg::OP_WRITE_BYTE: nack_q    <= nack_q | status.ack_missing;
                    eeprom_pkg::OP_READ_BYTE:  rdata_q   <= status.rbyte;
                    eeprom_pkg::OP_STOP:       rsp_valid <= 1'b1; // end of transaction
                    default:                   ;
                endcase
            end
        end
    end

endmodule

/* logic/eeprom_txn_decode.sv */
module eeprom_txn_decode (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    req_valid,
    input  eeprom_pkg::eeprom_req_t req,
    output logic                    busy,
    output logic                    txn_start,
    output logic                    txn_write,
    output logic                    op_valid,
    output eeprom_pkg::twi_op_t     op,
    input  logic                    op_done
);

    eeprom_pkg::seq_state_e  state;
    eeprom_pkg::seq_state_e  next_state;
    eeprom_pkg::eeprom_req_t req_q;
    logic                    issued;  // op sent, waiting for op_done
    logic                    advance;
    logic [7:0]              ctrl_byte;

    assign busy      = (state != eeprom_pkg::S_IDLE);
    assign txn_start = req_valid && !busy;
    assign txn_write = req.write;

    assign op_valid = busy && (state != eeprom_pkg::S_WAIT_DONE) && !issued;

    assign advance = (state == eeprom_pkg::S_IDLE)      ? txn_start :
                     (state == eeprom_pkg::S_WAIT_DONE) ? 1'b1 :
                     (issued && op_done);

    // upper address bits ride in the control byte
    assign ctrl_byte = {eeprom_pkg::EEPROM_DEV_CODE, req_q.addr[10:8],
                        state == eeprom_pkg::S_CTRL_R};

    always_comb
    begin
        op.op      = eeprom_pkg::OP_WRITE_BYTE;
        op.wbyte   = 8'h00;
        next_state = state;
        case (state)
            eeprom_pkg::S_IDLE:      next_state = eeprom_pkg::S_START;
            eeprom_pkg::S_START:
            begin
                op.op      = eeprom_pkg::OP_START;
                next_state = eeprom_pkg::S_CTRL_W;
            end
            eeprom_pkg::S_CTRL_W:
            begin
                op.wbyte   = ctrl_byte;
                next_state = eeprom_pkg::S_ADDR;
            end
            eeprom_pkg::S_ADDR:
            begin
                op.wbyte   = req_q.addr[7:0];
                next_state = req_q.write ? eeprom_pkg::S_DATA : eeprom_pkg::S_RESTART;
            end
            eeprom_pkg::S_DATA:
            begin
                op.wbyte   = req_q.wdata;
                next_state = eeprom_pkg::S_STOP;
            end
            eeprom_pkg::S_RESTART:
            begin
                op.op      = eeprom_pkg::OP_START;
                next_state = eeprom_pkg::S_CTRL_R;
            end
            eeprom_pkg::S_CTRL_R:
            begin
                op.wbyte   = ctrl_byte;
                next_state = eeprom_pkg::S_READ;
            end
            eeprom_pkg::S_READ:
            begin
                op.op      = eeprom_pkg::OP_READ_BYTE;
                next_state = eeprom_pkg::S_STOP;
            end
            eeprom_pkg::S_STOP:
            begin
                op.op      = eeprom_pkg::OP_STOP;
                next_state = eeprom_pkg::S_WAIT_DONE;
            end
            default:                 next_state = eeprom_pkg::S_IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= eeprom_pkg::S_IDLE;
            issued <= 1'b0;
        end
        else
        begin
            if (advance)
                state <= next_state;
            if (op_valid)
                issued <= 1'b1;
            else if (op_done)
                issued <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (txn_start)
            req_q <= req;
    end

endmodule

/* logic/twi_bit_engine.sv */
module twi_bit_engine #(
    parameter int SCL_HALF = 4
) (
    input  logic                    CLK,
    input  logic                    RESET,
    input  logic                    op_valid,
    input  eeprom_pkg::twi_op_t     op,
    output logic                    op_done,
    output eeprom_pkg::twi_status_t status,
    output logic                    scl,
    output logic                    sda_out,
    output logic                    sda_oe,
    input  logic                    sda_in
);

    localparam int               CNT_W    = $clog2(SCL_HALF);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SCL_HALF - 1);
    localparam logic [CNT_W-1:0] CNT_MID  = CNT_W'(SCL_HALF / 2);

    logic                active;
    logic                high_half;  // second half of the bit, scl high
    logic [CNT_W-1:0]    cnt;
    logic [3:0]          bit_cnt;
    eeprom_pkg::twi_op_e cur_op;
    logic [7:0]          shreg;
    logic                ack_missing;
    logic                is_byte;
    logic                ack_slot;
    logic                last_bit;
    logic                mid_point;

    assign is_byte   = (cur_op == eeprom_pkg::OP_WRITE_BYTE) ||
                       (cur_op == eeprom_pkg::OP_READ_BYTE);
    assign ack_slot  = (bit_cnt == 4'd8);
    assign last_bit  = is_byte ? ack_slot : 1'b1; // start and stop are one bit
    assign mid_point = active && (cnt == CNT_MID);

    assign status.op          = cur_op;
    assign status.rbyte       = shreg;
    assign status.ack_missing = ack_missing;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active    <= 1'b0;
            high_half <= 1'b0;
            cnt       <= '0;
            bit_cnt   <= 4'd0;
            op_done   <= 1'b0;
            scl       <= 1'b1;
            sda_out   <= 1'b1;
            sda_oe    <= 1'b0;
        end
        else
        begin
            op_done <= 1'b0;
            if (!active)
            begin
                if (op_valid)
                begin
                    active    <= 1'b1;
                    high_half <= 1'b0;
                    cnt       <= '0;
                    bit_cnt   <= 4'd0;
                end
            end
            else
            begin
                scl <= high_half;

                // sda moves mid half: data at scl low, start/stop at scl high
                if (mid_point && !high_half)
                begin
                    case (cur_op)
                        eeprom_pkg::OP_START:
                        begin
                            sda_oe  <= 1'b0;
                            sda_out <= 1'b1;
                        end
                        eeprom_pkg::OP_STOP:
                        begin
                            sda_oe  <= 1'b1;
                            sda_out <= 1'b0;
                        end
                        eeprom_pkg::OP_WRITE_BYTE:
                        begin
                            sda_oe  <= !ack_slot;  // release for device ack
                            sda_out <= shreg[7];
                        end
                        default:
                        begin
                            sda_oe  <= ack_slot;   // master NACK
                            sda_out <= 1'b1;
                        end
                    endcase
                end
                else if (mid_point && high_half)
                begin
                    if (cur_op == eeprom_pkg::OP_START)
                    begin
                        sda_oe  <= 1'b1;
                        sda_out <= 1'b0;
                    end
                    else if (cur_op == eeprom_pkg::OP_STOP)
                    begin
                        sda_oe  <= 1'b0;
                        sda_out <= 1'b1;
                    end
                end

                if (cnt == CNT_LAST)
                begin
                    cnt <= '0;
                    if (high_half)
                    begin
                        high_half <= 1'b0;
                        if (last_bit)
                        begin
                            active  <= 1'b0;
                            op_done <= 1'b1;
                        end
                        else
                            bit_cnt <= bit_cnt + 4'd1;
                    end
                    else
                        high_half <= 1'b1;
                end
                else
                    cnt <= cnt + 1'b1;
            end
        end
    end

    // shift register and ack flag
    always_ff @(posedge CLK)
    begin
        if (!active && op_valid)
        begin
            cur_op      <= op.op;
            shreg       <= op.wbyte;
            ack_missing <= 1'b0;
        end
        else if (mid_point && high_half && is_byte)
        begin
            if (ack_slot)
            begin
                if (cur_op == eeprom_pkg::OP_WRITE_BYTE)
                    ack_missing <= sda_in;  // high means no ack
            end
            else if (cur_op == eeprom_pkg::OP_WRITE_BYTE)
                shreg <= {shreg[6:0], 1'b0};
            else
                shreg <= {shreg[6:0], sda_in}; // msb first
        end
    end

endmodule

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_eeprom_ctrl -f src.f
./obj_dir/Vtb_eeprom_ctrl

/* src.f */
logic/eeprom_pkg.sv
logic/eeprom_txn_decode.sv
logic/twi_bit_engine.sv
logic/eeprom_rsp_collect.sv
logic/eeprom_ctrl_top.sv
testbench/eeprom_model.sv
testbench/eeprom_ctrl_properties.sv
testbench/tb_eeprom_ctrl.sv

/* testbench/eeprom_ctrl_properties.sv */
module eeprom_ctrl_properties (
    input logic                    CLK,
    input logic                    RESET,
    input logic                    scl,
    input logic                    sda_oe,
    input logic                    sda_in,
    input logic                    rsp_valid,
    input logic                    txn_start,
    input logic                    op_valid,
    input logic                    op_done,
    input eeprom_pkg::twi_status_t status
);

    logic outstanding;  // op handed to the engine and not yet answered

    always_ff @(posedge CLK)
    begin
        if (RESET)
            outstanding <= 1'b0;
        else if (op_valid)
            outstanding <= 1'b1;
        else if (op_done)
            outstanding <= 1'b0;
    end

    sda_moves_low: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && (sda_in != $past(sda_in))) |->
            (status.op == eeprom_pkg::OP_START || status.op == eeprom_pkg::OP_STOP))
        else $error("sda changed while scl high outside start or stop");

    rsp_one_cycle: assert property (@(posedge CLK) disable iff (RESET)
        rsp_valid |=> !rsp_valid)
        else $error("rsp_valid held longer than one cycle");

    one_op_at_a_time: assert property (@(posedge CLK) disable iff (RESET)
        op_valid |-> ($past(op_done) || $past(txn_start)))
        else $error("op_valid while an op is outstanding");

    done_answers_op: assert property (@(posedge CLK) disable iff (RESET)
        op_done |-> outstanding)
        else $error("op_done without an outstanding op");

    bus_idle_after_reset: assert property (@(posedge CLK)
        RESET |=> (!sda_oe && scl))
        else $error("bus not released after reset");

endmodule

bind eeprom_ctrl_top eeprom_ctrl_properties u_props (
    .CLK       (CLK),
    .RESET     (RESET),
    .scl       (scl),
    .sda_oe    (sda_oe),
    .sda_in    (sda_in),
    .rsp_valid (rsp_valid),
    .txn_start (txn_start),
    .op_valid  (op_valid),
    .op_done   (op_done),
    .status    (status)
);

/* testbench/eeprom_model.sv */
module eeprom_model (
    input  logic scl,
    input  logic sda,
    input  logic absent,
    output logic sda_drive  // low pulls the wire down
);

    typedef enum logic [2:0] {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_DATA,
        M_ACK_R,  // acking a read control byte
        M_READ,
        M_DONE
    } model_state_e;

    logic [7:0]   mem [0:2047];
    model_state_e state     = M_IDLE;
    logic         prev_scl  = 1'b1;
    logic         prev_sda  = 1'b1;
    logic         drive     = 1'b1;
    logic [3:0]   bit_cnt   = 4'hf;
    logic [7:0]   shreg     = 8'h00;
    logic [7:0]   tx        = 8'hff;
    logic [10:0]  addr      = 11'h000;
    logic [7:0]   wdata     = 8'h00;
    logic         have_data = 1'b0;

    assign sda_drive = drive;

    function automatic logic [7:0] power_up_byte(input logic [10:0] a);
        return a[7:0] ^ 8'h5a ^ {5'b00000, a[10:8]};
    endfunction

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = power_up_byte(i[10:0]);
    end

    always @(posedge scl or negedge scl or posedge sda or negedge sda)
    begin
        if (scl && prev_scl && prev_sda && !sda)
        begin
            drive     = 1'b1;  // start or repeated start
            have_data = 1'b0;
            bit_cnt   = 4'hf;
            state     = absent ? M_IDLE : M_CTRL;
        end
        else if (scl && prev_scl && !prev_sda && sda)
        begin
            if (have_data)
                mem[addr] = wdata; // write cycle runs at stop
            have_data = 1'b0;
            drive     = 1'b1;
            state     = M_IDLE;
        end
        else if (scl && !prev_scl && state != M_IDLE)
        begin
            if (state == M_READ)
            begin
                if (bit_cnt == 4'd8)
                    state = M_DONE;  // master nack ends the read
            end
            else if (bit_cnt < 4'd8)
                shreg = {shreg[6:0], sda};
        end
        else if (!scl && prev_scl && state != M_IDLE)
        begin
            if (bit_cnt == 4'hf)
                bit_cnt = 4'd0;  // first fall after start
            else if (bit_cnt == 4'd7)
            begin
                bit_cnt = 4'd8;
                drive   = 1'b1;
                case (state)
                    M_CTRL:
                    begin
                        if (shreg[7:4] == 4'b1010)
                        begin
                            addr[10:8] = shreg[3:1];
                            drive      = 1'b0;
                            if (shreg[0])
                            begin
                                tx    = mem[addr];
                                state = M_ACK_R;
                            end
                            else
                                state = M_ADDR;
                        end
                        else
                            state = M_IDLE;
                    end
                    M_ADDR:
                    begin
                        addr[7:0] = shreg;
                        drive     = 1'b0;
                        state     = M_DATA;
                    end
                    M_DATA:
                    begin
                        wdata     = shreg;
                        have_data = 1'b1;
                        drive     = 1'b0;
                        state     = M_DONE;
                    end
                    default: ;
                endcase
            end
            else if (bit_cnt == 4'd8)
            begin
                bit_cnt = 4'd0;
                drive   = 1'b1;
                if (state == M_ACK_R)
                begin
                    state = M_READ;
                    drive = tx[7];
                end
            end
            else
            begin
                bit_cnt = bit_cnt + 4'd1;
                if (state == M_READ)
                    drive = tx[3'd7 - bit_cnt[2:0]];
            end
        end
        prev_scl = scl;
        prev_sda = sda;
    end

endmodule

/* testbench/tb_eeprom_ctrl.sv */
module tb_eeprom_ctrl;

    localparam int SCL_HALF   = 4;
    // ~100 transactions of at most 48 bits, with margin
    localparam int TXN_COUNT  = 100;
    localparam int MAX_CYCLES = TXN_COUNT * 48 * 2 * SCL_HALF * 3 / 2 + 2000;

    logic                    CLK = 1'b0;
    logic                    RESET;
    logic                    req_valid;
    eeprom_pkg::eeprom_req_t req;
    logic                    busy;
    logic                    rsp_valid;
    eeprom_pkg::eeprom_rsp_t rsp;
    logic                    scl;
    logic                    sda_out;
    logic                    sda_oe;
    logic                    sda_in;
    logic                    model_drive;
    logic                    absent;

    logic [7:0]              shadow [0:2047];
    eeprom_pkg::eeprom_rsp_t want_q [$];
    int                      seed      = 32'h428b897e;
    int                      cycles    = 0;
    int                      acc_count = 0;
    int                      rsp_count = 0;

    always #20 CLK = ~CLK;

    assign sda_in = (sda_oe ? sda_out : 1'b1) & model_drive;  // open drain wire

    eeprom_ctrl_top #(
        .SCL_HALF (SCL_HALF)
    ) u_dut (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_valid (req_valid),
        .req       (req),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .scl       (scl),
        .sda_out   (sda_out),
        .sda_oe    (sda_oe),
        .sda_in    (sda_in)
    );

    eeprom_model u_model (
        .scl       (scl),
        .sda       (sda_in),
        .absent    (absent),
        .sda_drive (model_drive)
    );

    function automatic logic [7:0] initial_byte(input logic [10:0] a);
        return a[7:0] ^ 8'h5a ^ {5'b00000, a[10:8]};
    endfunction

    initial
    begin
        for (int i = 0; i < 2048; i++)
            shadow[i] = initial_byte(i[10:0]);
    end

    function automatic eeprom_pkg::eeprom_rsp_t expect_rsp(
        input eeprom_pkg::eeprom_req_t r,
        input logic                    dev_absent
    );
        eeprom_pkg::eeprom_rsp_t e;
        e.write = r.write;
        e.rdata = 8'h00;
        e.nack  = dev_absent;  // no device, no ack anywhere
        if (r.write)
        begin
            if (!dev_absent)
                shadow[r.addr] = r.wdata;
        end
        else
            e.rdata = dev_absent ? 8'hff : shadow[r.addr];
        return e;
    endfunction

    task automatic fail_run;
        $display("Testbench failed");
        $fatal(1, "run stopped at first error");
    endtask

    // called on a falling edge
    task automatic issue(input logic write, input logic [10:0] addr, input logic [7:0] data);
        eeprom_pkg::eeprom_req_t r;
        r.write = write;
        r.addr  = addr;
        r.wdata = data;
        while (busy)
            @(negedge CLK);
        req       = r;
        req_valid = 1'b1;
        want_q.push_back(expect_rsp(r, absent));
        acc_count++;
        @(negedge CLK);
        req_valid = 1'b0;
    endtask

    task automatic wait_rsp;
        while (rsp_count < acc_count)
            @(negedge CLK);
        assert (!busy)
        else
        begin
            $display("busy still high after the response");
            fail_run();
        end
    endtask

    task automatic transact(input logic write, input logic [10:0] addr, input logic [7:0] data);
        issue(write, addr, data);
        wait_rsp();
    endtask

    always @(posedge CLK)
    begin
        cycles++;
        assert (cycles < MAX_CYCLES)
        else
        begin
            $display("timeout, no end of test after %0d cycles", cycles);
            fail_run();
        end
    end

    always @(posedge CLK)
    begin
        eeprom_pkg::eeprom_rsp_t want;
        if (!RESET && rsp_valid)
        begin
            assert (want_q.size() != 0)
            else
            begin
                $display("response arrived with no accepted request outstanding");
                fail_run();
            end
            want = want_q.pop_front();
            assert (rsp.write == want.write)
            else
            begin
                $display("FAIL rsp.write expected %h got %h", want.write, rsp.write);
                fail_run();
            end
            assert (rsp.rdata == want.rdata)
            else
            begin
                $display("FAIL rsp.rdata expected %h got %h", want.rdata, rsp.rdata);
                fail_run();
            end
            assert (rsp.nack == want.nack)
            else
            begin
                $display("FAIL rsp.nack expected %h got %h", want.nack, rsp.nack);
                fail_run();
            end
            rsp_count++;
        end
    end

    initial
    begin
        logic [31:0]             rnd;
        logic [10:0]             a;
        eeprom_pkg::eeprom_req_t stray;

        RESET     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        absent    = 1'b0;
        a         = 11'h000;
        repeat (8) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);

        // fresh memory, one read per 256 byte block
        for (int blk = 0; blk < 8; blk++)
        begin
            rnd = $random(seed);
            transact(1'b0, {blk[2:0], rnd[7:0]}, 8'h00);
        end

        for (int n = 0; n < 40; n++)
        begin
            rnd = $random(seed);
            a   = rnd[10:0];
            transact(1'b1, a, rnd[23:16]);
            transact(1'b0, a, 8'h00);
        end

        absent = 1'b1;
        transact(1'b1, a, ~shadow[a]);
        transact(1'b0, a, 8'h00);
        absent = 1'b0;
        transact(1'b0, a, 8'h00);  // old byte survives

        // second strobe while busy is dropped
        rnd = $random(seed);
        issue(1'b1, rnd[10:0], rnd[23:16]);
        assert (busy)
        else
        begin
            $display("request was not accepted");
            fail_run();
        end
        stray.write = 1'b1;
        stray.addr  = rnd[10:0] ^ 11'h400;
        stray.wdata = ~shadow[stray.addr];
        req         = stray;
        req_valid   = 1'b1;
        @(negedge CLK);
        req_valid = 1'b0;
        wait_rsp();
        transact(1'b0, stray.addr, 8'h00);

        rnd = $random(seed);
        a   = rnd[10:0];
        for (int n = 0; n < 5; n++)
        begin
            rnd = $random(seed);
            transact(1'b1, a, rnd[7:0]);
        end
        transact(1'b0, a, 8'h00);

        repeat (60 * 2 * SCL_HALF) @(negedge CLK);  // room for a stray response
        if (want_q.size() == 0 && rsp_count == acc_count)
        begin
            $display("Testbench passed");
            $finish;
        end
        else
        begin
            $display("%0d responses for %0d accepted requests", rsp_count, acc_count);
            fail_run();
        end
    end

endmodule
